// File: Bender.yml
package:
  name: id_stage

export_include_dirs:
  - .

sources:
  - files:
      - id_pkg.sv
      - id_instr_fields.sv
      - id_cap_regfile.sv
      - id_operand_mux.sv
      - id_writeback.sv
      - id_multicycle_fsm.sv
      - id_stage_top.sv
  - target: test
    files:
      - id_stage_assert.sv
      - tb_id_stage.sv

// File: filelist.f
+incdir+.
id_pkg.sv
id_instr_fields.sv
id_cap_regfile.sv
id_operand_mux.sv
id_writeback.sv
id_multicycle_fsm.sv
id_stage_top.sv
id_stage_assert.sv
tb_id_stage.sv

// File: id_cap_regfile.sv
/*
 * Capability register file
 * Two combinational reads, one write, x0 hardwired to null
 */

`timescale 1ns/1ps

`include "id_defs.svh"

module id_cap_regfile (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  id_pkg::reg_addr_t raddr_a_i,
  input  id_pkg::reg_addr_t raddr_b_i,
  input  id_pkg::reg_addr_t waddr_i,
  input  id_pkg::cap_t      wdata_i,
  input  logic              we_i,
  output id_pkg::cap_t      rdata_a_o,
  output id_pkg::cap_t      rdata_b_o
);

  import id_pkg::*;

  cap_t rf_q [`ID_NREGS];

  // x0 holds no storage
  assign rf_q[0] = '0;

  for (genvar i = 1; i < `ID_NREGS; i++) begin : g_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_i && (waddr_i == reg_addr_t'(i))) begin
        rf_q[i] <= wdata_i;
      end
    end
  end

  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

endmodule

// File: id_defs.svh
/*
 * Width and position macros for the ID stage datapath
 * Capability, integer and register file geometry
 */

`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Capability word width
`define ID_CAP_W 93

// Integer width, also the address field of a capability
`define ID_XLEN 32

// Mode flag position inside a capability
`define ID_CAP_FLAG_BIT 92

// Register file geometry
`define ID_NREGS 32
`define ID_RADDR_W 5

`endif

// File: id_instr_fields.sv
/*
 * Instruction field extraction
 * Register addresses and base-ISA immediates
 */

`timescale 1ns/1ps

module id_instr_fields (
  input  id_pkg::word_t     instr_rdata_i,
  output id_pkg::reg_addr_t raddr_a_o,
  output id_pkg::reg_addr_t raddr_b_o,
  output id_pkg::reg_addr_t waddr_o,
  output id_pkg::word_t     imm_i_o,
  output id_pkg::word_t     imm_s_o,
  output id_pkg::word_t     imm_b_o,
  output id_pkg::word_t     imm_u_o,
  output id_pkg::word_t     imm_j_o,
  output id_pkg::word_t     zimm_o
);

  // rs1, rs2, rd
  assign raddr_a_o = instr_rdata_i[19:15];
  assign raddr_b_o = instr_rdata_i[24:20];
  assign waddr_o   = instr_rdata_i[11:7];

  // Sign bit is always instr[31]
  assign imm_i_o = {{21{instr_rdata_i[31]}}, instr_rdata_i[30:20]};
  assign imm_s_o = {{21{instr_rdata_i[31]}}, instr_rdata_i[30:25], instr_rdata_i[11:7]};
  assign imm_b_o = {{20{instr_rdata_i[31]}}, instr_rdata_i[7], instr_rdata_i[30:25],
                    instr_rdata_i[11:8], 1'b0};
  assign imm_u_o = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_o = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                    instr_rdata_i[30:21], 1'b0};

  // CSR-style immediate from the rs1 field
  assign zimm_o = {27'b0, instr_rdata_i[19:15]};

endmodule

// File: id_multicycle_fsm.sv
/*
 * Multicycle instruction tracker
 * Stalls for LSU, mult/div, jumps and taken branches, branch set and retire
 */

`timescale 1ns/1ps

module id_multicycle_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_new_i,
  input  logic data_req_i,
  input  logic multdiv_en_i,
  input  logic branch_i,
  input  logic jump_i,
  input  logic branch_decision_i,
  input  logic ex_valid_i,
  input  logic lsu_valid_i,
  input  logic rf_we_i,
  output logic stall_o,
  output logic branch_set_o,
  output logic instr_ret_o,
  output logic instr_executing_o,
  output logic rf_we_wb_o,
  output logic multicycle_o,
  output logic data_req_o
);

  import id_pkg::*;

  id_fsm_e fsm_cs, fsm_ns;
  logic    done_q, done_n;
  logic    branch_set_q, branch_set_n;
  logic    multi_done;

  // Completion pulse depends on the unit doing the work
  assign multi_done = (data_req_i & lsu_valid_i) | (~data_req_i & ex_valid_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_cs       <= IDLE;
      done_q       <= 1'b1;
      branch_set_q <= 1'b0;
    end else begin
      fsm_cs       <= fsm_ns;
      done_q       <= done_n;
      branch_set_q <= branch_set_n;
    end
  end

  always_comb begin
    fsm_ns       = fsm_cs;
    done_n       = done_q;
    branch_set_n = 1'b0;
    stall_o      = 1'b0;
    instr_ret_o  = 1'b0;
    rf_we_wb_o   = 1'b0;

    unique case (fsm_cs)
      IDLE: begin
        // Only a new instruction can start a wait
        if (instr_new_i) begin
          if (data_req_i || multdiv_en_i || jump_i) begin
            fsm_ns  = WAIT_MULTI;
            stall_o = 1'b1;
            done_n  = 1'b0;
          end else if (branch_i && branch_decision_i) begin
            fsm_ns       = WAIT_MULTI;
            stall_o      = 1'b1;
            done_n       = 1'b0;
            branch_set_n = 1'b1;
          end else begin
            // Not-taken branch or single-cycle op
            instr_ret_o = 1'b1;
          end
        end
      end

      WAIT_MULTI: begin
        if (multi_done) begin
          fsm_ns      = IDLE;
          done_n      = 1'b1;
          instr_ret_o = 1'b1;
          rf_we_wb_o  = rf_we_i;
        end else begin
          stall_o = 1'b1;
        end
      end

      default: fsm_ns = IDLE;
    endcase
  end

  assign branch_set_o      = branch_set_q;
  assign instr_executing_o = instr_new_i | ~done_q;
  assign data_req_o        = data_req_i & instr_executing_o;
  assign multicycle_o      = data_req_i | multdiv_en_i;

endmodule

// File: id_operand_mux.sv
/*
 * Operand selection for the ALU and the CHERI unit
 * Memory capability choice and store data
 */

`timescale 1ns/1ps

`include "id_defs.svh"

module id_operand_mux (
  input  id_pkg::cap_t         rdata_a_cap_i,
  input  id_pkg::cap_t         rdata_b_cap_i,
  input  id_pkg::cap_t         pc_cap_i,
  input  id_pkg::cap_t         ddc_i,
  input  id_pkg::reg_addr_t    raddr_a_i,
  input  id_pkg::reg_addr_t    raddr_b_i,
  input  id_pkg::word_t        imm_i_i,
  input  id_pkg::word_t        imm_s_i,
  input  id_pkg::word_t        imm_b_i,
  input  id_pkg::word_t        imm_u_i,
  input  id_pkg::word_t        imm_j_i,
  input  id_pkg::word_t        zimm_i,
  input  logic                 instr_is_compressed_i,
  input  id_pkg::op_a_sel_e    alu_op_a_sel_i,
  input  id_pkg::op_b_sel_e    alu_op_b_sel_i,
  input  id_pkg::imm_a_sel_e   imm_a_sel_i,
  input  id_pkg::imm_b_sel_e   imm_b_sel_i,
  input  id_pkg::c_op_a_sel_e  c_op_a_sel_i,
  input  id_pkg::c_op_b_sel_e  c_op_b_sel_i,
  input  id_pkg::c_imm_b_sel_e c_imm_b_sel_i,
  input  logic                 mem_ddc_relative_i,
  input  logic                 cheri_en_i,
  input  logic                 mem_cap_access_i,
  output id_pkg::word_t        alu_operand_a_o,
  output id_pkg::word_t        alu_operand_b_o,
  output id_pkg::cap_t         cheri_operand_a_o,
  output id_pkg::cap_t         cheri_operand_b_o,
  output id_pkg::cap_t         mem_cap_o,
  output id_pkg::cap_t         data_wdata_o
);

  import id_pkg::*;

  word_t rdata_a;
  word_t rdata_b;
  word_t imm_a;
  word_t imm_b;
  word_t pc_incr;
  cap_t  c_imm_b;
  logic  use_ddc;

  // Integer value placed in the address field of an otherwise empty word
  function automatic cap_t zext(input word_t w);
    return cap_t'(w);
  endfunction

  // Integer view of the register reads
  assign rdata_a = rdata_a_cap_i[`ID_XLEN-1:0];
  assign rdata_b = rdata_b_cap_i[`ID_XLEN-1:0];

  assign pc_incr = instr_is_compressed_i ? 32'h2 : 32'h4;

  ////////////////////////////////////////////////////////////////////////////
  // Integer operands
  ////////////////////////////////////////////////////////////////////////////

  assign imm_a = (imm_a_sel_i == IMM_A_ZIMM) ? zimm_i : '0;

  always_comb begin
    unique case (alu_op_a_sel_i)
      OP_A_REG:    alu_operand_a_o = rdata_a;
      OP_A_CURRPC: alu_operand_a_o = pc_cap_i[`ID_XLEN-1:0];
      OP_A_IMM:    alu_operand_a_o = imm_a;
      default:     alu_operand_a_o = '0;
    endcase
  end

  always_comb begin
    unique case (imm_b_sel_i)
      IMM_B_I:       imm_b = imm_i_i;
      IMM_B_S:       imm_b = imm_s_i;
      IMM_B_B:       imm_b = imm_b_i;
      IMM_B_U:       imm_b = imm_u_i;
      IMM_B_J:       imm_b = imm_j_i;
      IMM_B_INCR_PC: imm_b = pc_incr;
      default:       imm_b = '0;
    endcase
  end

  assign alu_operand_b_o = (alu_op_b_sel_i == OP_B_IMM) ? imm_b : rdata_b;

  ////////////////////////////////////////////////////////////////////////////
  // CHERI operands
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (c_op_a_sel_i)
      C_OP_A_REG_CAP: cheri_operand_a_o = rdata_a_cap_i;
      C_OP_A_REG_NUM: cheri_operand_a_o = zext(rdata_a);
      // x0 stands for DDC here
      C_OP_A_REG_DDC: cheri_operand_a_o = (raddr_a_i == '0) ? ddc_i : rdata_a_cap_i;
      C_OP_A_PCC:     cheri_operand_a_o = pc_cap_i;
      default:        cheri_operand_a_o = '0;
    endcase
  end

  always_comb begin
    unique case (c_imm_b_sel_i)
      C_IMM_B_INCR_PC: c_imm_b = zext(pc_incr);
      C_IMM_B_I:       c_imm_b = zext(imm_i_i);
      C_IMM_B_S:       c_imm_b = zext(imm_s_i);
      C_IMM_B_U:       c_imm_b = zext(imm_u_i);
      C_IMM_B_RS2:     c_imm_b = zext(word_t'(raddr_b_i));
      default:         c_imm_b = '0;
    endcase
  end

  always_comb begin
    unique case (c_op_b_sel_i)
      C_OP_B_IMM:     cheri_operand_b_o = c_imm_b;
      C_OP_B_REG_CAP: cheri_operand_b_o = rdata_b_cap_i;
      C_OP_B_REG_NUM: cheri_operand_b_o = zext(rdata_b);
      C_OP_B_REG_DDC: cheri_operand_b_o = (raddr_b_i == '0) ? ddc_i : rdata_b_cap_i;
      C_OP_B_PCC:     cheri_operand_b_o = pc_cap_i;
      default:        cheri_operand_b_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory capability and store data
  ////////////////////////////////////////////////////////////////////////////

  // Legacy code in integer mode always goes through DDC
  assign use_ddc = mem_ddc_relative_i | (~cheri_en_i & ~pc_cap_i[`ID_CAP_FLAG_BIT]);

  assign mem_cap_o = use_ddc ? ddc_i : rdata_a_cap_i;

  assign data_wdata_o = mem_cap_access_i ? rdata_b_cap_i : zext(rdata_b);

endmodule

// File: id_pkg.sv
/*
 * Shared types for the ID stage
 * Capability, word and register address types
 * Operand, immediate and writeback select encodings, FSM states
 */

`include "id_defs.svh"

package id_pkg;

  typedef logic [`ID_CAP_W-1:0]   cap_t;
  typedef logic [`ID_XLEN-1:0]    word_t;
  typedef logic [`ID_RADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Integer operand selects
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {OP_A_REG, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;

  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;

  typedef enum logic {IMM_A_ZERO, IMM_A_ZIMM} imm_a_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // CHERI operand selects
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    C_OP_A_REG_CAP, C_OP_A_REG_NUM, C_OP_A_REG_DDC, C_OP_A_PCC
  } c_op_a_sel_e;

  typedef enum logic [2:0] {
    C_OP_B_IMM, C_OP_B_REG_CAP, C_OP_B_REG_NUM, C_OP_B_REG_DDC, C_OP_B_PCC
  } c_op_b_sel_e;

  typedef enum logic [2:0] {
    C_IMM_B_INCR_PC, C_IMM_B_I, C_IMM_B_S, C_IMM_B_U, C_IMM_B_RS2
  } c_imm_b_sel_e;

  // Writeback source
  typedef enum logic [1:0] {RF_WD_EX, RF_WD_LSU, RF_WD_CHERI} rf_wd_sel_e;

  // Multicycle tracker states
  typedef enum logic {IDLE, WAIT_MULTI} id_fsm_e;

endpackage

// File: id_stage_assert.sv
/*
 * Concurrent checks bound into the ID stage top level
 * Stall, branch set, retire and register write timing
 */

`timescale 1ns/1ps

module id_stage_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_new_i,
  input logic data_req_i,
  input logic multdiv_en_i,
  input logic jump_i,
  input logic branch_i,
  input logic branch_decision_i,
  input logic stall_i,
  input logic branch_set_i,
  input logic instr_ret_i,
  input logic data_req_out_i,
  input logic rf_we_int_i
);

  int unsigned fail_cnt = 0;

  logic new_multi;
  logic new_taken;

  assign new_multi = instr_new_i & (data_req_i | multdiv_en_i | jump_i);
  assign new_taken = instr_new_i & branch_i & branch_decision_i;

  // Quiet outputs while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !stall_i && !branch_set_i && !instr_ret_i && !data_req_out_i)
    else begin
      fail_cnt++;
      $error("outputs active during reset");
    end

  multi_stalls: assert property (@(posedge clk_i) disable iff (!rst_ni)
    new_multi |-> stall_i)
    else begin
      fail_cnt++;
      $error("new multicycle instruction did not stall");
    end

  taken_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    new_taken |-> stall_i ##1 branch_set_i ##1 !branch_set_i)
    else begin
      fail_cnt++;
      $error("taken branch set timing wrong");
    end

  branch_set_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_set_i |-> $past(new_taken))
    else begin
      fail_cnt++;
      $error("branch set without a taken branch");
    end

  not_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_i && branch_i && !branch_decision_i && !new_multi |-> instr_ret_i && !stall_i)
    else begin
      fail_cnt++;
      $error("not-taken branch did not retire at once");
    end

  no_ret_in_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |-> !instr_ret_i)
    else begin
      fail_cnt++;
      $error("retire while stalled");
    end

  // Loads and mult/div hold their write until completion
  no_early_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i && (data_req_i || multdiv_en_i) |-> !rf_we_int_i)
    else begin
      fail_cnt++;
      $error("register write during a stall");
    end

  ret_on_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(stall_i) |-> instr_ret_i)
    else begin
      fail_cnt++;
      $error("stall released without retire");
    end

  // Retire only for a new instruction or at the end of a wait
  ret_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_ret_i |-> instr_new_i || $past(stall_i))
    else begin
      fail_cnt++;
      $error("retire without a new or completing instruction");
    end

  // Request stays up for as long as the load/store sits in ID
  data_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i && (instr_new_i || stall_i) |-> data_req_out_i)
    else begin
      fail_cnt++;
      $error("data request dropped while the load/store was in ID");
    end

endmodule

bind id_stage_top id_stage_assert u_id_stage_assert (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .instr_new_i       (instr_new_i),
  .data_req_i        (data_req_i),
  .multdiv_en_i      (multdiv_en_i),
  .jump_i            (jump_i),
  .branch_i          (branch_i),
  .branch_decision_i (branch_decision_i),
  .stall_i           (stall_o),
  .branch_set_i      (branch_set_o),
  .instr_ret_i       (instr_ret_o),
  .data_req_out_i    (data_req_o),
  .rf_we_int_i       (rf_we)
);

// File: id_stage_top.sv
/*
 * ID stage operand and writeback datapath, top level
 * Field extraction, register file, operand mux, writeback, tracker
 */

`timescale 1ns/1ps

module id_stage_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  id_pkg::word_t        instr_rdata_i,
  input  logic                 instr_new_i,
  input  logic                 instr_is_compressed_i,
  input  id_pkg::cap_t         pc_cap_i,
  input  id_pkg::cap_t         ddc_i,
  input  id_pkg::op_a_sel_e    alu_op_a_sel_i,
  input  id_pkg::op_b_sel_e    alu_op_b_sel_i,
  input  id_pkg::imm_a_sel_e   imm_a_sel_i,
  input  id_pkg::imm_b_sel_e   imm_b_sel_i,
  input  id_pkg::c_op_a_sel_e  c_op_a_sel_i,
  input  id_pkg::c_op_b_sel_e  c_op_b_sel_i,
  input  id_pkg::c_imm_b_sel_e c_imm_b_sel_i,
  input  logic                 mem_ddc_relative_i,
  input  logic                 cheri_en_i,
  input  logic                 mem_cap_access_i,
  input  logic                 cheri_wrote_cap_i,
  input  id_pkg::rf_wd_sel_e   rf_wd_sel_i,
  input  logic                 rf_we_i,
  input  logic                 data_req_i,
  input  logic                 multdiv_en_i,
  input  logic                 branch_i,
  input  logic                 jump_i,
  input  logic                 branch_decision_i,
  input  logic                 ex_valid_i,
  input  logic                 lsu_valid_i,
  input  id_pkg::cap_t         ex_wdata_i,
  input  id_pkg::cap_t         lsu_wdata_i,
  output id_pkg::word_t        alu_operand_a_o,
  output id_pkg::word_t        alu_operand_b_o,
  output id_pkg::cap_t         cheri_operand_a_o,
  output id_pkg::cap_t         cheri_operand_b_o,
  output id_pkg::cap_t         mem_cap_o,
  output id_pkg::cap_t         data_wdata_o,
  output logic                 stall_o,
  output logic                 branch_set_o,
  output logic                 instr_ret_o,
  output logic                 data_req_o
);

  import id_pkg::*;

  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  reg_addr_t waddr;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_u;
  word_t     imm_j;
  word_t     zimm;
  cap_t      rdata_a_cap;
  cap_t      rdata_b_cap;
  cap_t      rf_wdata;
  logic      rf_we;
  logic      rf_we_wb;
  logic      instr_executing;
  logic      multicycle;

  id_instr_fields u_instr_fields (
    .instr_rdata_i (instr_rdata_i),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .waddr_o       (waddr),
    .imm_i_o       (imm_i),
    .imm_s_o       (imm_s),
    .imm_b_o       (imm_b),
    .imm_u_o       (imm_u),
    .imm_j_o       (imm_j),
    .zimm_o        (zimm)
  );

  id_cap_regfile u_cap_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a_cap),
    .rdata_b_o (rdata_b_cap)
  );

  // Selects, PC, DDC and operand outputs share the top-level names
  id_operand_mux u_operand_mux (
    .rdata_a_cap_i (rdata_a_cap),
    .rdata_b_cap_i (rdata_b_cap),
    .raddr_a_i     (raddr_a),
    .raddr_b_i     (raddr_b),
    .imm_i_i       (imm_i),
    .imm_s_i       (imm_s),
    .imm_b_i       (imm_b),
    .imm_u_i       (imm_u),
    .imm_j_i       (imm_j),
    .zimm_i        (zimm),
    .*
  );

  id_writeback u_writeback (
    .multicycle_i      (multicycle),
    .instr_executing_i (instr_executing),
    .rf_we_wb_i        (rf_we_wb),
    .wdata_o           (rf_wdata),
    .we_o              (rf_we),
    .*
  );

  id_multicycle_fsm u_multicycle_fsm (
    .instr_executing_o (instr_executing),
    .rf_we_wb_o        (rf_we_wb),
    .multicycle_o      (multicycle),
    .*
  );

endmodule

// File: id_writeback.sv
/*
 * Register file writeback selection
 * Tag stripping into address-only capabilities, write enable gating
 */

`timescale 1ns/1ps

`include "id_defs.svh"

module id_writeback (
  input  id_pkg::cap_t       ex_wdata_i,
  input  id_pkg::cap_t       lsu_wdata_i,
  input  id_pkg::rf_wd_sel_e rf_wd_sel_i,
  input  logic               mem_cap_access_i,
  input  logic               cheri_wrote_cap_i,
  input  logic               rf_we_i,
  input  logic               multicycle_i,
  input  logic               instr_executing_i,
  input  logic               rf_we_wb_i,
  output id_pkg::cap_t       wdata_o,
  output logic               we_o
);

  import id_pkg::*;

  // Null capability keeping only the address field
  function automatic cap_t null_with_addr(input cap_t cap);
    cap_t res;
    res = '0;
    res[`ID_XLEN-1:0] = cap[`ID_XLEN-1:0];
    return res;
  endfunction

  always_comb begin
    unique case (rf_wd_sel_i)
      RF_WD_EX:    wdata_o = null_with_addr(ex_wdata_i);
      RF_WD_LSU:   wdata_o = mem_cap_access_i ? lsu_wdata_i : null_with_addr(lsu_wdata_i);
      RF_WD_CHERI: wdata_o = cheri_wrote_cap_i ? ex_wdata_i : null_with_addr(ex_wdata_i);
      default:     wdata_o = '0;
    endcase
  end

  // Loads and mult/div write only when their result arrives
  assign we_o = multicycle_i ? rf_we_wb_i : (rf_we_i & instr_executing_i);

endmodule

// File: tb_id_stage.sv
/*
 * Testbench for the ID stage datapath
 * Clock, reset, LFSR stimulus and reference register model
 * Directed tests for writeback, operands, memory capability, stalls, branches
 */

`timescale 1ns/1ps

`include "id_defs.svh"

module tb_id_stage;

  import id_pkg::*;

  localparam int N_WB    = 24;
  localparam int N_INT   = 8;
  localparam int N_CHERI = 8;
  localparam int N_MEM   = 8;
  localparam int N_STALL = 8;
  localparam int N_BR    = 8;
  localparam int WATCHDOG_CYCLES = (N_WB + N_INT + N_CHERI + N_MEM + N_STALL + N_BR) * 20;

  logic         clk_i;
  logic         rst_ni;
  word_t        instr_rdata_i;
  logic         instr_new_i;
  logic         instr_is_compressed_i;
  cap_t         pc_cap_i;
  cap_t         ddc_i;
  op_a_sel_e    alu_op_a_sel_i;
  op_b_sel_e    alu_op_b_sel_i;
  imm_a_sel_e   imm_a_sel_i;
  imm_b_sel_e   imm_b_sel_i;
  c_op_a_sel_e  c_op_a_sel_i;
  c_op_b_sel_e  c_op_b_sel_i;
  c_imm_b_sel_e c_imm_b_sel_i;
  logic         mem_ddc_relative_i;
  logic         cheri_en_i;
  logic         mem_cap_access_i;
  logic         cheri_wrote_cap_i;
  rf_wd_sel_e   rf_wd_sel_i;
  logic         rf_we_i;
  logic         data_req_i;
  logic         multdiv_en_i;
  logic         branch_i;
  logic         jump_i;
  logic         branch_decision_i;
  logic         ex_valid_i;
  logic         lsu_valid_i;
  cap_t         ex_wdata_i;
  cap_t         lsu_wdata_i;
  word_t        alu_operand_a_o;
  word_t        alu_operand_b_o;
  cap_t         cheri_operand_a_o;
  cap_t         cheri_operand_b_o;
  cap_t         mem_cap_o;
  cap_t         data_wdata_o;
  logic         stall_o;
  logic         branch_set_o;
  logic         instr_ret_o;
  logic         data_req_o;

  // Reference copy of the register file
  cap_t        rf_model [`ID_NREGS];
  logic [15:0] lfsr_q;
  int          checks;
  int          errors;
  int          test_err0;

  id_stage_top id_stage_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random source and checks
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic cap_t rand_bits(input int n);
    cap_t r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[`ID_CAP_W-2:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Base-ISA immediate encodings
  function automatic word_t expected_imm(input word_t ins, input imm_b_sel_e sel,
                                         input logic cmp);
    case (sel)
      IMM_B_I: return word_t'($signed(ins[31:20]));
      IMM_B_S: return word_t'($signed({ins[31:25], ins[11:7]}));
      IMM_B_B: return word_t'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
      IMM_B_U: return {ins[31:12], 12'h000};
      IMM_B_J: return word_t'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
      default: return cmp ? 32'd2 : 32'd4;
    endcase
  endfunction

  task automatic check_val(input string name, input cap_t got, input cap_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Failure at %0t: %s", $time, what);
    end
  endtask

  task automatic end_test(input string name);
    $display("%-24s %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  task automatic clear_ctrl();
    instr_new_i       <= 1'b0;
    rf_we_i           <= 1'b0;
    data_req_i        <= 1'b0;
    multdiv_en_i      <= 1'b0;
    branch_i          <= 1'b0;
    jump_i            <= 1'b0;
    branch_decision_i <= 1'b0;
    ex_valid_i        <= 1'b0;
    lsu_valid_i       <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic read_back(input reg_addr_t ra, input reg_addr_t rb);
    @(posedge clk_i);
    instr_rdata_i <= {7'h00, rb, ra, 3'h0, 5'h00, 7'h5b};
    c_op_a_sel_i  <= C_OP_A_REG_CAP;
    c_op_b_sel_i  <= C_OP_B_REG_CAP;
    @(negedge clk_i);
    check_val("cheri_operand_a_o", cheri_operand_a_o, rf_model[ra]);
    check_val("cheri_operand_b_o", cheri_operand_b_o, rf_model[rb]);
  endtask

  // Single-cycle write through one writeback source
  task automatic write_reg(input reg_addr_t rd, input rf_wd_sel_e sel);
    cap_t ex_d;
    cap_t lsu_d;
    cap_t exp;
    logic mca;
    logic wrc;
    ex_d  = rand_bits(`ID_CAP_W);
    lsu_d = rand_bits(`ID_CAP_W);
    mca   = 1'(rand_bits(1));
    wrc   = 1'(rand_bits(1));
    case (sel)
      RF_WD_LSU:   exp = mca ? lsu_d : cap_t'(lsu_d[`ID_XLEN-1:0]);
      RF_WD_CHERI: exp = wrc ? ex_d : cap_t'(ex_d[`ID_XLEN-1:0]);
      default:     exp = cap_t'(ex_d[`ID_XLEN-1:0]);
    endcase
    @(posedge clk_i);
    instr_rdata_i     <= {20'h0, rd, 7'h33};
    rf_wd_sel_i       <= sel;
    ex_wdata_i        <= ex_d;
    lsu_wdata_i       <= lsu_d;
    mem_cap_access_i  <= mca;
    cheri_wrote_cap_i <= wrc;
    instr_new_i       <= 1'b1;
    rf_we_i           <= 1'b1;
    @(posedge clk_i);
    clear_ctrl();
    if (rd != '0) begin
      rf_model[rd] = exp;
    end
  endtask

  // Kind 0 is a load, 1 a multiply, 2 a taken branch
  task automatic run_multicycle(input int kind, input int lat);
    reg_addr_t rd;
    cap_t      wdata;
    rd    = reg_addr_t'(rand_bits(5)) | 5'd1;
    wdata = rand_bits(`ID_CAP_W);
    @(posedge clk_i);
    instr_rdata_i     <= {20'h0, rd, 7'h03};
    instr_new_i       <= 1'b1;
    rf_we_i           <= (kind != 2);
    data_req_i        <= (kind == 0);
    multdiv_en_i      <= (kind == 1);
    branch_i          <= (kind == 2);
    branch_decision_i <= (kind == 2);
    rf_wd_sel_i       <= (kind == 0) ? RF_WD_LSU : RF_WD_EX;
    mem_cap_access_i  <= 1'b1;
    lsu_wdata_i       <= wdata;
    ex_wdata_i        <= wdata;
    @(negedge clk_i);
    check_flag(stall_o && !branch_set_o, "no stall on a new multicycle instruction");
    @(posedge clk_i);
    instr_new_i <= 1'b0;
    for (int c = 0; c < lat; c++) begin
      @(negedge clk_i);
      check_flag(stall_o && !instr_ret_o, "stall released before the completion pulse");
      if (kind == 2) begin
        check_flag(branch_set_o == (c == 0), "branch_set_o not in exactly the next cycle");
      end
      @(posedge clk_i);
    end
    if (kind == 0) begin
      lsu_valid_i <= 1'b1;
    end else begin
      ex_valid_i <= 1'b1;
    end
    @(negedge clk_i);
    check_flag(!stall_o && instr_ret_o, "no retire in the completion cycle");
    @(posedge clk_i);
    clear_ctrl();
    if (kind == 0) begin
      rf_model[rd] = wdata;
    end else if (kind == 1) begin
      rf_model[rd] = cap_t'(wdata[`ID_XLEN-1:0]);
    end
    read_back(rd, rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reg_addr_t ra;
    reg_addr_t rb;
    word_t     ins;
    cap_t      pc;
    cap_t      ddc;
    logic      cmp;
    logic      flag;
    logic      rel;
    logic      cen;
    logic      mca;
    int        total;
    lfsr_q    = 16'd4002;
    checks    = 0;
    errors    = 0;
    test_err0 = 0;
    for (int r = 0; r < `ID_NREGS; r++) begin
      rf_model[r] = '0;
    end
    rst_ni                <= 1'b0;
    instr_rdata_i         <= '0;
    instr_is_compressed_i <= 1'b0;
    pc_cap_i              <= '0;
    ddc_i                 <= '0;
    alu_op_a_sel_i        <= OP_A_REG;
    alu_op_b_sel_i        <= OP_B_REG;
    imm_a_sel_i           <= IMM_A_ZERO;
    imm_b_sel_i           <= IMM_B_I;
    c_op_a_sel_i          <= C_OP_A_REG_CAP;
    c_op_b_sel_i          <= C_OP_B_REG_CAP;
    c_imm_b_sel_i         <= C_IMM_B_I;
    mem_ddc_relative_i    <= 1'b0;
    cheri_en_i            <= 1'b0;
    mem_cap_access_i      <= 1'b0;
    cheri_wrote_cap_i     <= 1'b0;
    rf_wd_sel_i           <= RF_WD_EX;
    ex_wdata_i            <= '0;
    lsu_wdata_i           <= '0;
    clear_ctrl();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Every eighth write targets x0
    for (int n = 0; n < N_WB; n++) begin
      ra = (n % 8 == 7) ? '0 : reg_addr_t'(rand_bits(5));
      write_reg(ra, rf_wd_sel_e'(2'(n % 3)));
      read_back(ra, ra);
    end
    end_test("writeback and read-back");

    for (int n = 0; n < N_INT; n++) begin
      ins = word_t'(rand_bits(32));
      cmp = 1'(rand_bits(1));
      pc  = rand_bits(`ID_CAP_W);
      @(posedge clk_i);
      instr_rdata_i         <= ins;
      instr_is_compressed_i <= cmp;
      pc_cap_i              <= pc;
      alu_op_a_sel_i        <= OP_A_CURRPC;
      alu_op_b_sel_i        <= OP_B_IMM;
      for (int s = 0; s < 6; s++) begin
        imm_b_sel_i <= imm_b_sel_e'(3'(s));
        @(negedge clk_i);
        check_val("alu_operand_b_o", cap_t'(alu_operand_b_o),
                  cap_t'(expected_imm(ins, imm_b_sel_e'(3'(s)), cmp)));
        check_val("alu_operand_a_o", cap_t'(alu_operand_a_o), cap_t'(pc[`ID_XLEN-1:0]));
        @(posedge clk_i);
      end
    end
    end_test("integer operands");

    for (int n = 0; n < N_CHERI; n++) begin
      ra  = (n % 2 == 0) ? '0 : reg_addr_t'(rand_bits(5));
      rb  = reg_addr_t'(rand_bits(5));
      ddc = rand_bits(`ID_CAP_W);
      @(posedge clk_i);
      instr_rdata_i <= {7'h00, rb, ra, 3'h0, 5'h00, 7'h5b};
      ddc_i         <= ddc;
      c_op_a_sel_i  <= C_OP_A_REG_DDC;
      c_op_b_sel_i  <= C_OP_B_IMM;
      c_imm_b_sel_i <= C_IMM_B_RS2;
      @(negedge clk_i);
      check_val("cheri_operand_a_o", cheri_operand_a_o, (ra == '0) ? ddc : rf_model[ra]);
      check_val("cheri_operand_b_o", cheri_operand_b_o, cap_t'(rb));
    end
    end_test("CHERI operands");

    for (int n = 0; n < N_MEM; n++) begin
      ra   = reg_addr_t'(rand_bits(5));
      rb   = reg_addr_t'(rand_bits(5));
      flag = 1'(rand_bits(1));
      rel  = 1'(rand_bits(1));
      cen  = 1'(rand_bits(1));
      mca  = 1'(rand_bits(1));
      ddc  = rand_bits(`ID_CAP_W);
      pc   = rand_bits(`ID_CAP_W);
      pc[`ID_CAP_FLAG_BIT] = flag;
      @(posedge clk_i);
      instr_rdata_i      <= {7'h00, rb, ra, 3'h2, 5'h00, 7'h23};
      pc_cap_i           <= pc;
      ddc_i              <= ddc;
      mem_ddc_relative_i <= rel;
      cheri_en_i         <= cen;
      mem_cap_access_i   <= mca;
      @(negedge clk_i);
      check_val("mem_cap_o", mem_cap_o, (rel || (!cen && !flag)) ? ddc : rf_model[ra]);
      check_val("data_wdata_o", data_wdata_o,
                mca ? rf_model[rb] : cap_t'(rf_model[rb][`ID_XLEN-1:0]));
    end
    end_test("memory capability");

    for (int n = 0; n < N_STALL; n++) begin
      run_multicycle(n % 2, 1 + int'(rand_bits(2)));
    end
    end_test("load/store and mult stalls");

    for (int n = 0; n < N_BR; n++) begin
      if (n % 2 == 0) begin
        run_multicycle(2, 1 + int'(rand_bits(2)));
      end else begin
        @(posedge clk_i);
        instr_new_i <= 1'b1;
        branch_i    <= 1'b1;
        @(negedge clk_i);
        check_flag(!stall_o && instr_ret_o, "not-taken branch did not retire at once");
        @(posedge clk_i);
        clear_ctrl();
        @(negedge clk_i);
        check_flag(!branch_set_o, "branch_set_o raised by a not-taken branch");
      end
    end
    end_test("branches");

    @(posedge clk_i);
    total = errors + int'(id_stage_top_i.u_id_stage_assert.fail_cnt);
    $display("Checks: %0d, check errors: %0d, total failures: %0d", checks, errors, total);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
